//--- common/vrc6_pkg.sv
// ====================
// shared widths, register map and step count for the VRC6 sound unit
// imported by the RTL and the testbench
// ====================

`default_nettype none

package vrc6_pkg;

    // CPU bus
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // channel registers
    typedef logic [11:0] period_t;     // divider reload value
    typedef logic [3:0]  pulse_vol_t;  // pulse volume and pulse level
    typedef logic [2:0]  duty_t;
    typedef logic [3:0]  duty_step_t;  // 16 steps per pulse cycle

    // sawtooth
    typedef logic [5:0]  saw_rate_t;   // added to the accumulator each step
    typedef logic [7:0]  saw_acc_t;
    typedef logic [4:0]  saw_level_t;  // top five accumulator bits

    // mixed output
    typedef logic [15:0] snd_level_t;

    // register bases, one per channel
    localparam cpu_addr_t PULSE1_BASE = 16'h9000;
    localparam cpu_addr_t PULSE2_BASE = 16'hA000;
    localparam cpu_addr_t SAW_BASE    = 16'hB000;

    // offsets inside each base
    localparam cpu_addr_t REG_CTRL    = 16'h0000;
    localparam cpu_addr_t REG_FREQ_LO = 16'h0001;
    localparam cpu_addr_t REG_FREQ_HI = 16'h0002;

    // accumulate steps before the saw wraps to zero
    localparam int SAW_STEPS = 6;

endpackage

`default_nettype wire

//--- common/pulse_cfg_if.sv
// ====================
// register set of one pulse channel
// driven by the decoder, read by the pulse channel
// ====================

`timescale 1ns/1ns
`default_nettype none

interface pulse_cfg_if;
    import vrc6_pkg::*;

    logic       en;      // FREQ_HI bit 7
    logic       mode;    // constant level, duty ignored
    duty_t      duty;
    pulse_vol_t vol;
    period_t    period;

    // register side
    modport decode (
        output en,
        output mode,
        output duty,
        output vol,
        output period
    );

    // channel side
    modport chan (
        input en,
        input mode,
        input duty,
        input vol,
        input period
    );

endinterface

`default_nettype wire

//--- src/vrc6_reg_decode.sv
// ====================
// CPU write decoder and register file for the three channels
// variant high selects the board with address bits 1 and 0 exchanged
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_reg_decode (
    input  wire                   clk20,
    input  wire                   reset,
    input  wire                   ce,
    input  wire                   wr,
    input  vrc6_pkg::cpu_addr_t   addr,
    input  vrc6_pkg::cpu_data_t   data,
    input  wire                   variant,
    pulse_cfg_if.decode           pulse1_cfg,
    pulse_cfg_if.decode           pulse2_cfg,
    output logic                  saw_en,
    output vrc6_pkg::saw_rate_t   saw_rate,
    output vrc6_pkg::period_t     saw_period
);
    import vrc6_pkg::*;

    cpu_addr_t addr_sw;  // address after the variant swap
    logic      wr_en;

    assign addr_sw = variant ? {addr[15:2], addr[0], addr[1]} : addr;
    assign wr_en   = wr & ce;  // single-cycle write strobe

    // channel enables
    always_ff @(posedge clk20, posedge reset) begin
        if (reset) begin
            pulse1_cfg.en <= 1'b0;
            pulse2_cfg.en <= 1'b0;
            saw_en        <= 1'b0;
        end else if (wr_en) begin
            case (addr_sw)
                PULSE1_BASE + REG_FREQ_HI: pulse1_cfg.en <= data[7];
                PULSE2_BASE + REG_FREQ_HI: pulse2_cfg.en <= data[7];
                SAW_BASE + REG_FREQ_HI:    saw_en        <= data[7];
                default: ;
            endcase
        end
    end

    // volume, duty, rate and period registers
    always_ff @(posedge clk20) begin
        if (wr_en) begin
            case (addr_sw)
                PULSE1_BASE + REG_CTRL: begin
                    pulse1_cfg.mode <= data[7];
                    pulse1_cfg.duty <= data[6:4];
                    pulse1_cfg.vol  <= data[3:0];
                end
                PULSE1_BASE + REG_FREQ_LO: pulse1_cfg.period[7:0]  <= data;
                PULSE1_BASE + REG_FREQ_HI: pulse1_cfg.period[11:8] <= data[3:0];

                PULSE2_BASE + REG_CTRL: begin
                    pulse2_cfg.mode <= data[7];
                    pulse2_cfg.duty <= data[6:4];
                    pulse2_cfg.vol  <= data[3:0];
                end
                PULSE2_BASE + REG_FREQ_LO: pulse2_cfg.period[7:0]  <= data;
                PULSE2_BASE + REG_FREQ_HI: pulse2_cfg.period[11:8] <= data[3:0];

                SAW_BASE + REG_CTRL:    saw_rate          <= data[5:0];  // bits 7..6 unused
                SAW_BASE + REG_FREQ_LO: saw_period[7:0]   <= data;
                SAW_BASE + REG_FREQ_HI: saw_period[11:8]  <= data[3:0];
                default: ;  // other addresses ignored
            endcase
        end
    end

endmodule

`default_nettype wire

//--- channels/vrc6_pulse.sv
// ====================
// one VRC6 pulse channel
// divider clocks a 16-step duty counter, level is vol or zero
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_pulse (
    input  wire                    clk20,
    input  wire                    reset,
    input  wire                    ce,
    pulse_cfg_if.chan              cfg,
    output vrc6_pkg::pulse_vol_t   level
);
    import vrc6_pkg::*;

    period_t    div;   // counts down to zero, then reloads
    duty_step_t step;
    logic       duty_high;

    // counters hold while the channel is disabled
    always_ff @(posedge clk20, posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
        end else if (ce && cfg.en) begin
            if (div != '0) begin
                div <= div - 1'b1;
            end else begin
                div  <= cfg.period;
                step <= step + 1'b1;  // wraps after 16 steps
            end
        end
    end

    // high for steps 0..duty, so duty+1 of every 16
    assign duty_high = (step <= duty_step_t'(cfg.duty));

    assign level = (cfg.en && (cfg.mode || duty_high)) ? cfg.vol : '0;

endmodule

`default_nettype wire

//--- channels/vrc6_saw.sv
// ====================
// VRC6 sawtooth channel
// accumulates rate every second divider period, clears after SAW_STEPS steps
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_saw (
    input  wire                    clk20,
    input  wire                    reset,
    input  wire                    ce,
    input  wire                    en,
    input  vrc6_pkg::saw_rate_t    rate,
    input  vrc6_pkg::period_t      period,
    output vrc6_pkg::saw_level_t   level
);
    import vrc6_pkg::*;

    logic [$bits(period_t):0] div;  // one bit wider, reload is 2*period+1
    logic [2:0]               step;
    saw_acc_t                 acc;

    always_ff @(posedge clk20, posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
            acc  <= '0;
        end else if (ce && en) begin
            if (div != '0) begin
                div <= div - 1'b1;
            end else begin
                div <= {period, 1'b1};
                if (step == 3'(SAW_STEPS)) begin
                    // end of the ramp
                    step <= '0;
                    acc  <= '0;
                end else begin
                    step <= step + 1'b1;
                    acc  <= acc + saw_acc_t'(rate);
                end
            end
        end
    end

    assign level = en ? acc[7:3] : '0;  // top five bits only

endmodule

`default_nettype wire

//--- src/vrc6_mixer.sv
// ====================
// sums the two pulse levels and the saw level
// registered once, widened to the 16-bit sound level
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_mixer (
    input  wire                    clk20,
    input  wire                    reset,
    input  vrc6_pkg::pulse_vol_t   pulse1_level,
    input  vrc6_pkg::pulse_vol_t   pulse2_level,
    input  vrc6_pkg::saw_level_t   saw_level,
    output vrc6_pkg::snd_level_t   snd_level
);
    import vrc6_pkg::*;

    snd_level_t level_sum;  // 0..61, 15 + 15 + 31

    assign level_sum = snd_level_t'(pulse1_level)
                     + snd_level_t'(pulse2_level)
                     + snd_level_t'(saw_level);

    always_ff @(posedge clk20, posedge reset) begin
        if (reset) begin
            snd_level <= '0;
        end else begin
            snd_level <= level_sum;  // one cycle behind the channels
        end
    end

endmodule

`default_nettype wire

//--- src/vrc6_sound.sv
// ====================
// VRC6 expansion sound, top level
// CPU register writes in, one 16-bit sound level out
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_sound (
    input  wire                    clk20,
    input  wire                    reset,
    input  wire                    ce,
    input  wire                    wr,
    input  vrc6_pkg::cpu_addr_t    addr,
    input  vrc6_pkg::cpu_data_t    data,
    input  wire                    variant,  // high for the swapped-address board
    output vrc6_pkg::snd_level_t   snd_level
);
    import vrc6_pkg::*;

    pulse_cfg_if pulse1_cfg ();
    pulse_cfg_if pulse2_cfg ();

    logic       saw_en;
    saw_rate_t  saw_rate;
    period_t    saw_period;
    pulse_vol_t pulse1_level;
    pulse_vol_t pulse2_level;
    saw_level_t saw_level;

    vrc6_reg_decode u_decode (
        .clk20      (clk20),
        .reset      (reset),
        .ce         (ce),
        .wr         (wr),
        .addr       (addr),
        .data       (data),
        .variant    (variant),
        .pulse1_cfg (pulse1_cfg.decode),
        .pulse2_cfg (pulse2_cfg.decode),
        .saw_en     (saw_en),
        .saw_rate   (saw_rate),
        .saw_period (saw_period)
    );

    vrc6_pulse u_pulse1 (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .cfg   (pulse1_cfg.chan),
        .level (pulse1_level)
    );

    vrc6_pulse u_pulse2 (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .cfg   (pulse2_cfg.chan),
        .level (pulse2_level)
    );

    vrc6_saw u_saw (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .en     (saw_en),
        .rate   (saw_rate),
        .period (saw_period),
        .level  (saw_level)
    );

    vrc6_mixer u_mixer (
        .clk20        (clk20),
        .reset        (reset),
        .pulse1_level (pulse1_level),
        .pulse2_level (pulse2_level),
        .saw_level    (saw_level),
        .snd_level    (snd_level)
    );

endmodule

`default_nettype wire

//--- sim/vrc6_sound_asserts.sv
// ====================
// concurrent checks on the register decoder
// bound into every vrc6_reg_decode instance
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_sound_asserts (
    input wire                   clk20,
    input wire                   reset,
    input wire                   wr_en,
    input vrc6_pkg::cpu_addr_t   addr_sw,
    input vrc6_pkg::cpu_data_t   data,
    input wire                   p1_en,
    input wire                   p2_en,
    input wire                   saw_en,
    input vrc6_pkg::pulse_vol_t  p1_vol,
    input vrc6_pkg::pulse_vol_t  p2_vol,
    input wire [60:0]            cfg_regs  // every register bit, concatenated
);
    import vrc6_pkg::*;

    // enables cleared while reset is high
    enables_reset: assert property (@(posedge clk20) reset |-> !(p1_en || p2_en || saw_en))
        else $error("channel enable set during reset");

    regs_hold: assert property (@(posedge clk20) disable iff (reset)
        !wr_en |=> $stable(cfg_regs))
        else $error("register changed without a write strobe");

    p1_vol_write: assert property (@(posedge clk20) disable iff (reset)
        (wr_en && addr_sw == PULSE1_BASE + REG_CTRL) |=> (p1_vol == $past(data[3:0])))
        else $error("pulse 1 volume not updated by CTRL write");

    p2_vol_write: assert property (@(posedge clk20) disable iff (reset)
        (wr_en && addr_sw == PULSE2_BASE + REG_CTRL) |=> (p2_vol == $past(data[3:0])))
        else $error("pulse 2 volume not updated by CTRL write");

endmodule

bind vrc6_reg_decode vrc6_sound_asserts u_asserts (
    .clk20    (clk20),
    .reset    (reset),
    .wr_en    (wr_en),
    .addr_sw  (addr_sw),
    .data     (data),
    .p1_en    (pulse1_cfg.en),
    .p2_en    (pulse2_cfg.en),
    .saw_en   (saw_en),
    .p1_vol   (pulse1_cfg.vol),
    .p2_vol   (pulse2_cfg.vol),
    .cfg_regs ({pulse1_cfg.en, pulse1_cfg.mode, pulse1_cfg.duty, pulse1_cfg.vol,
                pulse1_cfg.period, pulse2_cfg.en, pulse2_cfg.mode, pulse2_cfg.duty,
                pulse2_cfg.vol, pulse2_cfg.period, saw_en, saw_rate, saw_period})
);

`default_nettype wire

//--- sim/vrc6_sound_tb.sv
// ====================
// testbench for the VRC6 sound top level
// drives CPU writes on the falling edge and checks snd_level against reference rules
// ====================

`timescale 1ns/1ns
`default_nettype none

module vrc6_sound_tb;
    import vrc6_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int DUTY_WINDOW  = 32 * 16;             // 32 full pulse cycles at period 0
    localparam int SAW_WINDOW   = 200;
    localparam int SAW_RAMP     = 2 * (SAW_STEPS + 1);  // one ramp at period 0
    // rough length of each test in cycles
    localparam int LEN_RESET    = RESET_CYCLES + 30;
    localparam int LEN_CONST    = 40;
    localparam int LEN_DUTY     = DUTY_WINDOW + 20;
    localparam int LEN_SAW      = SAW_WINDOW + SAW_RAMP + 20;
    localparam int LEN_OFF      = 40 + SAW_RAMP;
    localparam int CYCLE_LIMIT  = 2 * (LEN_RESET + 2 * LEN_CONST + LEN_DUTY
                                       + 2 * LEN_SAW + LEN_OFF);

    logic       clk20;
    logic       reset;
    logic       ce;
    logic       wr;
    cpu_addr_t  addr;
    cpu_data_t  data;
    logic       variant;
    snd_level_t snd_level;

    logic [31:0] lcg_state;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          cycles = 0;

    vrc6_sound i_dut (
        .clk20     (clk20),
        .reset     (reset),
        .ce        (ce),
        .wr        (wr),
        .addr      (addr),
        .data      (data),
        .variant   (variant),
        .snd_level (snd_level)
    );

    initial begin
        clk20 = 1'b0;
        forever #10 clk20 = ~clk20;
    end

    // hung run guard
    always @(posedge clk20) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick(input int lo, input int hi, output int val);
        lcg_state = lcg_next(lcg_state);
        val = lo + int'(lcg_state[30:16]) % (hi - lo + 1);
    endtask

    // reference rules
    function automatic int exp_pulse_high(input int duty);
        return duty + 1;  // high steps out of 16
    endfunction

    function automatic snd_level_t exp_saw_peak(input int rate);
        return snd_level_t'((SAW_STEPS * rate) / 8);
    endfunction

    // register address as the board sees it
    function automatic cpu_addr_t reg_addr(input cpu_addr_t base, input cpu_addr_t offs);
        cpu_addr_t a;
        a = base + offs;
        if (variant) begin
            a = {a[15:2], a[0], a[1]};  // bits 1 and 0 exchanged
        end
        return a;
    endfunction

    task automatic check_level(input snd_level_t got, input snd_level_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, snd_level %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Mismatch at %0t ns: %s, count %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    // all tasks below start and end on a falling edge
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk20);
    endtask

    task automatic cpu_write(input cpu_addr_t a, input cpu_data_t d);
        wr   = 1'b1;
        ce   = 1'b1;
        addr = a;
        data = d;
        @(negedge clk20);
        wr   = 1'b0;
    endtask

    task automatic set_channel(input cpu_addr_t base, input cpu_data_t ctrl,
                               input period_t period, input logic en);
        cpu_write(reg_addr(base, REG_CTRL), ctrl);
        cpu_write(reg_addr(base, REG_FREQ_LO), period[7:0]);
        cpu_write(reg_addr(base, REG_FREQ_HI), {en, 3'b000, period[11:8]});
    endtask

    task automatic mute_channel(input cpu_addr_t base);
        cpu_write(reg_addr(base, REG_FREQ_HI), 8'h00);
    endtask

    task automatic mute_all();
        mute_channel(PULSE1_BASE);
        mute_channel(PULSE2_BASE);
        mute_channel(SAW_BASE);
    endtask

    task automatic run_reset();
        begin_test();
        repeat (20) begin
            check_level(snd_level, '0, "level after reset");
            @(negedge clk20);
        end
        report_test("reset");
    endtask

    task automatic run_constant(input string name);
        int v1;
        int v2;
        begin_test();
        pick(1, 15, v1);
        pick(1, 15, v2);
        mute_all();
        set_channel(PULSE1_BASE, {4'b1000, 4'(v1)}, 12'h000, 1'b1);
        wait_cycles(2);
        check_level(snd_level, snd_level_t'(v1), "pulse 1 constant");
        mute_channel(PULSE1_BASE);
        set_channel(PULSE2_BASE, {4'b1000, 4'(v2)}, 12'h000, 1'b1);
        wait_cycles(2);
        check_level(snd_level, snd_level_t'(v2), "pulse 2 constant");
        cpu_write(reg_addr(PULSE1_BASE, REG_FREQ_HI), 8'h80);
        wait_cycles(2);
        check_level(snd_level, snd_level_t'(v1 + v2), "both pulses constant");
        report_test(name);
    endtask

    task automatic run_duty();
        int duty;
        int vol;
        int high;
        begin_test();
        pick(0, 7, duty);
        pick(1, 15, vol);
        high = 0;
        mute_all();
        set_channel(PULSE1_BASE, {1'b0, 3'(duty), 4'(vol)}, 12'h000, 1'b1);
        wait_cycles(2);
        repeat (DUTY_WINDOW) begin
            if (snd_level != '0) begin
                high++;
            end
            @(negedge clk20);
        end
        check_count(high, (DUTY_WINDOW / 16) * exp_pulse_high(duty), "pulse 1 high samples");
        report_test("duty");
    endtask

    task automatic run_saw(input string name);
        int         rate;
        snd_level_t peak;
        logic       risen;
        logic       back_to_zero;
        begin_test();
        pick(11, 42, rate);  // 6*42 still fits the 8-bit accumulator
        peak = '0;
        risen = 1'b0;
        back_to_zero = 1'b0;
        mute_all();
        set_channel(SAW_BASE, {2'b00, 6'(rate)}, 12'h000, 1'b1);
        wait_cycles(SAW_RAMP + 2);  // lets a leftover ramp from an earlier run finish
        repeat (SAW_WINDOW) begin
            if (snd_level > peak) begin
                peak = snd_level;
            end
            if (snd_level != '0) begin
                risen = 1'b1;
            end else if (risen) begin
                back_to_zero = 1'b1;
            end
            @(negedge clk20);
        end
        check_level(peak, exp_saw_peak(rate), "saw peak");
        check_count(int'(back_to_zero), 1, "saw returns to zero");
        mute_channel(SAW_BASE);
        report_test(name);
    endtask

    task automatic run_disable();
        int v1;
        int v2;
        begin_test();
        pick(1, 15, v1);
        pick(1, 15, v2);
        set_channel(PULSE1_BASE, {4'b1000, 4'(v1)}, 12'h000, 1'b1);
        set_channel(PULSE2_BASE, {4'b1000, 4'(v2)}, 12'h000, 1'b1);
        set_channel(SAW_BASE, 8'h2a, 12'h000, 1'b1);
        wait_cycles(10);
        mute_channel(SAW_BASE);
        wait_cycles(2);
        // a running saw would show up somewhere in a full ramp
        repeat (SAW_RAMP) begin
            check_level(snd_level, snd_level_t'(v1 + v2), "saw disabled");
            @(negedge clk20);
        end
        mute_channel(PULSE1_BASE);
        wait_cycles(2);
        check_level(snd_level, snd_level_t'(v2), "pulse 1 disabled");
        mute_channel(PULSE2_BASE);
        wait_cycles(2);
        check_level(snd_level, '0, "pulse 2 disabled");
        report_test("disable");
    endtask

    initial begin
        reset     = 1'b1;
        ce        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        data      = '0;
        variant   = 1'b0;
        lcg_state = 32'h51b5_2154;
        repeat (RESET_CYCLES) @(negedge clk20);
        reset = 1'b0;
        ce    = 1'b1;  // free-running from here

        run_reset();
        run_constant("constant");
        run_duty();
        run_saw("sawtooth");
        run_disable();
        variant = 1'b1;
        run_constant("variant constant");
        run_saw("variant sawtooth");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vrc6_sound.f
common/vrc6_pkg.sv
common/pulse_cfg_if.sv
src/vrc6_reg_decode.sv
channels/vrc6_pulse.sv
channels/vrc6_saw.sv
src/vrc6_mixer.sv
src/vrc6_sound.sv
sim/vrc6_sound_asserts.sv
sim/vrc6_sound_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the VRC6 sound testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vrc6_sound_tb \
    -f vrc6_sound.f -o vrc6_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vrc6_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0
